//--- banked_sram.f
hdl/banked_sram_pkg.sv
hdl/write_fifo.sv
hdl/bank_arbiter.sv
hdl/bank_array.sv
hdl/banked_sram.sv
tests/banked_sram_checker.sv
tests/banked_sram_tb.sv

//--- Makefile
TOP = banked_sram_tb

.PHONY: sim clean

sim:
	verilator --binary --timing -j 0 --top-module $(TOP) -f banked_sram.f
	@out="$$(./obj_dir/V$(TOP))"; \
	echo "$$out"; \
	echo "$$out" | grep -q "Regression passed"

clean:
	rm -rf obj_dir

//--- tests/banked_sram_tests.txt
# op name mask addr0 addr1 addr2 addr3 data0 data1 data2 data3 flags
# op: W write, R read (data is expected), F flags check ({busy, full}), D drain
F reset_state f 0000 0000 0000 0000 00000000 00000000 00000000 00000000 00
W interleave_w0 1 0000 0000 0000 0000 10000000 00000000 00000000 00000000 00
W interleave_w1 1 0001 0000 0000 0000 10000001 00000000 00000000 00000000 00
W interleave_w2 1 0002 0000 0000 0000 10000002 00000000 00000000 00000000 00
W interleave_w3 1 0003 0000 0000 0000 10000003 00000000 00000000 00000000 00
W interleave_w4 1 0004 0000 0000 0000 10000004 00000000 00000000 00000000 00
W interleave_w5 1 0005 0000 0000 0000 10000005 00000000 00000000 00000000 00
W interleave_w6 1 0006 0000 0000 0000 10000006 00000000 00000000 00000000 00
W interleave_w7 1 0007 0000 0000 0000 10000007 00000000 00000000 00000000 00
D interleave_dr 0 0000 0000 0000 0000 00000000 00000000 00000000 00000000 00
R interleave_r0 f 0000 0000 0000 0000 10000000 10000000 10000000 10000000 00
R interleave_r1 f 0001 0001 0001 0001 10000001 10000001 10000001 10000001 00
R interleave_r2 f 0002 0002 0002 0002 10000002 10000002 10000002 10000002 00
R interleave_r3 f 0003 0003 0003 0003 10000003 10000003 10000003 10000003 00
R interleave_r4 f 0004 0004 0004 0004 10000004 10000004 10000004 10000004 00
R interleave_r5 f 0005 0005 0005 0005 10000005 10000005 10000005 10000005 00
R interleave_r6 f 0006 0006 0006 0006 10000006 10000006 10000006 10000006 00
R interleave_r7 f 0007 0007 0007 0007 10000007 10000007 10000007 10000007 00
W distinct_write f 0011 0022 0033 0040 a0000011 a1000022 a2000033 a3000040 00
D distinct_drain 0 0000 0000 0000 0000 00000000 00000000 00000000 00000000 00
R distinct_read f 0011 0022 0033 0040 a0000011 a1000022 a2000033 a3000040 00
W same_bank_write f 0502 0606 070a 080e b0000502 b1000606 b200070a b300080e 00
D same_bank_drain 0 0000 0000 0000 0000 00000000 00000000 00000000 00000000 00
R same_bank_read f 0502 0606 070a 080e b0000502 b1000606 b200070a b300080e 00
W collision_write 9 0123 0000 0000 0123 aaaa0123 00000000 00000000 bbbb0123 00
D collision_drain 0 0000 0000 0000 0000 00000000 00000000 00000000 00000000 00
R collision_read f 0123 0123 0123 0123 bbbb0123 bbbb0123 bbbb0123 bbbb0123 00
W bp_preload 8 0000 0000 0000 0410 00000000 00000000 00000000 5a5a0410 00
D bp_preload_dr 0 0000 0000 0000 0000 00000000 00000000 00000000 00000000 00
W bp_write1 f 0100 0200 0300 0400 c0000100 c1000200 c2000300 33000001 00
W bp_write2 f 0104 0204 0304 0404 c0000104 c1000204 c2000304 33000002 00
W bp_write3 f 0108 0208 0308 0408 c0000108 c1000208 c2000308 33000003 00
W bp_write4 f 010c 020c 030c 040c c000010c c100020c c200030c 33000004 00
W bp_write5 f 0110 0210 0310 0410 c0000110 c1000210 c2000310 33000005 00
F bp_full f 0000 0000 0000 0000 00000000 00000000 00000000 00000000 1e
D bp_drain 0 0000 0000 0000 0000 00000000 00000000 00000000 00000000 00
R bp_rows f 0400 0404 0408 040c 33000001 33000002 33000003 33000004 00
R bp_dropped_row 1 0410 0000 0000 0000 5a5a0410 00000000 00000000 00000000 00

//--- tests/banked_sram_tb.sv
`timescale 1ns/10ps

module banked_sram_tb
    import banked_sram_pkg::*;
();

    localparam int    CLK_HALF     = 4;
    localparam int    RESET_CYCLES = 16;
    localparam int    DRAIN_LIMIT  = 200;
    localparam string STIM_FILE    = "tests/banked_sram_tests.txt";

    logic                 clk;
    logic                 reset;
    mem_addr_u            addr [NUM_PORTS];
    logic [NUM_PORTS-1:0] we;
    word_t                wd [NUM_PORTS];
    word_t                rd [NUM_PORTS];
    logic [NUM_PORTS-1:0] full;
    logic                 busy;

    // Requests toward the checker
    logic                 check_read;
    logic                 check_flags;
    logic                 timed_out;
    logic                 report;
    logic [127:0]         test_name;
    logic [NUM_PORTS-1:0] port_mask;
    word_t                exp_rd [NUM_PORTS];
    logic [NUM_PORTS-1:0] exp_full;
    logic                 exp_busy;
    int                   stim_errors;
    int                   mismatch_count;
    int                   timeout_count;

    // Current line of the stimulus file
    logic [7:0]           line_op;
    logic [127:0]         line_name;
    logic [NUM_PORTS-1:0] line_mask;
    logic [ADDR_BITS-1:0] line_addr [NUM_PORTS];
    word_t                line_data [NUM_PORTS];
    logic [4:0]           line_flags;

    always #CLK_HALF clk = ~clk;

    banked_sram #(
        .FIFO_DEPTH (4)
    ) banked_sram_i (
        .clk   (clk),
        .reset (reset),
        .addr  (addr),
        .we    (we),
        .wd    (wd),
        .rd    (rd),
        .full  (full),
        .busy  (busy)
    );

    banked_sram_checker checker_i (
        .clk            (clk),
        .reset          (reset),
        .rd             (rd),
        .full           (full),
        .busy           (busy),
        .check_read     (check_read),
        .check_flags    (check_flags),
        .timed_out      (timed_out),
        .report         (report),
        .test_name      (test_name),
        .port_mask      (port_mask),
        .exp_rd         (exp_rd),
        .exp_full       (exp_full),
        .exp_busy       (exp_busy),
        .stim_errors    (stim_errors),
        .mismatch_count (mismatch_count),
        .timeout_count  (timeout_count)
    );

    //////////////////////////////////////////////////////////////
    // Every line starts on a falling edge
    //////////////////////////////////////////////////////////////

    task automatic clear_requests();
        we          = '0;
        check_read  = 1'b0;
        check_flags = 1'b0;
        timed_out   = 1'b0;
    endtask

    // Busy is sampled between edges where it has settled
    task automatic wait_drain();
        int cycles;

        cycles = 0;
        while (busy && (cycles < DRAIN_LIMIT))
        begin
            @(negedge clk);
            cycles++;
        end
        if (busy)
            timed_out = 1'b1;
    endtask

    task automatic run_line();
        @(negedge clk);
        clear_requests();
        test_name = line_name;
        port_mask = line_mask;
        case (line_op)
            "W", "R":
            begin
                for (int p = 0; p < NUM_PORTS; p++)
                begin
                    if (line_mask[p])
                    begin
                        addr[p].flat = line_addr[p];
                        wd[p]        = line_data[p];
                        exp_rd[p]    = line_data[p];
                    end
                end
                we         = (line_op == "W") ? line_mask : '0;
                check_read = (line_op == "R");
            end
            "F":
            begin
                exp_full    = line_flags[NUM_PORTS-1:0];
                exp_busy    = line_flags[4];
                check_flags = 1'b1;
            end
            "D": wait_drain();
            default:
            begin
                $display("Unknown operation %s in line %s", line_op, line_name);
                stim_errors++;
            end
        endcase
    endtask

    //////////////////////////////////////////////////////////////
    // Main sequence
    //////////////////////////////////////////////////////////////

    initial
    begin : main
        int    fd;
        int    n;
        string line;

        clk         = 1'b0;
        reset       = 1'b1;
        report      = 1'b0;
        test_name   = '0;
        port_mask   = '0;
        exp_full    = '0;
        exp_busy    = 1'b0;
        stim_errors = 0;
        clear_requests();
        for (int p = 0; p < NUM_PORTS; p++)
        begin
            addr[p]   = '0;
            wd[p]     = '0;
            exp_rd[p] = '0;
        end

        fd = $fopen(STIM_FILE, "r");
        if (fd == 0)
        begin
            $display("Cannot open stimulus file %s", STIM_FILE);
            $display("Regression failed");
            $finish;
        end
        else
        begin
            repeat (RESET_CYCLES) @(posedge clk);
            @(negedge clk);
            reset = 1'b0;

            // One line per cycle while drains take as long as they need
            while (!$feof(fd))
            begin
                line = "";
                n = $fgets(line, fd);
                if ((line.len() > 0) && (line.getc(0) != "#"))
                begin
                    n = $sscanf(line, "%s %s %h %h %h %h %h %h %h %h %h %h",
                                line_op, line_name, line_mask,
                                line_addr[0], line_addr[1], line_addr[2], line_addr[3],
                                line_data[0], line_data[1], line_data[2], line_data[3],
                                line_flags);
                    if (n == 12)
                        run_line();
                    else if (n > 0)
                    begin
                        $display("Malformed stimulus line: %s", line);
                        stim_errors++;
                    end
                end
            end
            $fclose(fd);

            @(negedge clk);
            clear_requests();
            report = 1'b1;
            @(posedge clk);
            #1;
            if ((mismatch_count + timeout_count + stim_errors) == 0)
                $display("Regression passed");
            else
                $display("Regression failed");
            $finish;
        end
    end

endmodule

//--- tests/banked_sram_checker.sv
`timescale 1ns/10ps

module banked_sram_checker
    import banked_sram_pkg::*;
(
    input  logic                 clk,
    input  logic                 reset,
    input  word_t                rd [NUM_PORTS],
    input  logic [NUM_PORTS-1:0] full,
    input  logic                 busy,
    input  logic                 check_read,
    input  logic                 check_flags,
    input  logic                 timed_out,
    input  logic                 report,
    input  logic [127:0]         test_name,
    input  logic [NUM_PORTS-1:0] port_mask,
    input  word_t                exp_rd [NUM_PORTS],
    input  logic [NUM_PORTS-1:0] exp_full,
    input  logic                 exp_busy,
    input  int                   stim_errors,
    output int                   mismatch_count,
    output int                   timeout_count
);

    ////////////////////////////////////////////////////////////
    // Comparison at every rising edge
    ////////////////////////////////////////////////////////////

    always @(posedge clk or posedge reset)
    begin : compare
        int errs;

        errs = 0;
        if (reset)
        begin
            mismatch_count <= 0;
            timeout_count  <= 0;
        end
        else
        begin
            // Read data of every selected port
            if (check_read)
            begin
                for (int p = 0; p < NUM_PORTS; p++)
                begin
                    if (port_mask[p] && (rd[p] !== exp_rd[p]))
                    begin
                        $display("Fail %s port %0d: expected %h, actual %h",
                                 test_name, p, exp_rd[p], rd[p]);
                        errs++;
                    end
                end
            end

            // Status outputs
            if (check_flags)
            begin
                if (full !== exp_full)
                begin
                    $display("Fail %s full: expected %b, actual %b", test_name, exp_full, full);
                    errs++;
                end
                if (busy !== exp_busy)
                begin
                    $display("Fail %s busy: expected %b, actual %b", test_name, exp_busy, busy);
                    errs++;
                end
            end

            if (timed_out)
            begin
                $display("Timeout: DUT still busy at the end of drain %s", test_name);
                timeout_count <= timeout_count + 1;
            end

            mismatch_count <= mismatch_count + errs;

            if (report)
                $display("Checks complete: %0d mismatches, %0d timeouts, %0d stimulus errors",
                         mismatch_count, timeout_count, stim_errors);
        end
    end

endmodule

//--- hdl/banked_sram.sv
`timescale 1ns/10ps

module banked_sram
    import banked_sram_pkg::*;
#(
    parameter int FIFO_DEPTH = 4
)
(
    input  logic                 clk,
    input  logic                 reset,
    input  mem_addr_u            addr [NUM_PORTS],
    input  logic [NUM_PORTS-1:0] we,
    input  word_t                wd [NUM_PORTS],
    output word_t                rd [NUM_PORTS],
    output logic [NUM_PORTS-1:0] full,
    output logic                 busy
);

    // FIFO heads toward the arbiter
    mem_addr_u            head_addr [NUM_PORTS];
    word_t                head_data [NUM_PORTS];
    logic [NUM_PORTS-1:0] not_empty;
    logic [NUM_PORTS-1:0] pop;

    // Arbiter toward the banks
    logic [NUM_BANKS-1:0] bank_load;
    logic [ROW_BITS-1:0]  bank_row  [NUM_BANKS];
    word_t                bank_data [NUM_BANKS];
    logic [NUM_BANKS-1:0] pending;

    ////////////////////////////////////////////////////////////
    // Per-port write queues
    ////////////////////////////////////////////////////////////

    for (genvar p = 0; p < NUM_PORTS; p++)
    begin : g_port
        write_fifo #(
            .FIFO_DEPTH (FIFO_DEPTH)
        ) write_fifo_i (
            .clk        (clk),
            .reset      (reset),
            .push       (we[p]),
            .push_addr  (addr[p]),
            .push_data  (wd[p]),
            .pop        (pop[p]),
            .head_addr  (head_addr[p]),
            .head_data  (head_data[p]),
            .not_empty  (not_empty[p]),
            .full       (full[p])
        );
    end

    ////////////////////////////////////////////////////////////
    // Bank conflict resolution and storage
    ////////////////////////////////////////////////////////////

    bank_arbiter bank_arbiter_i (
        .head_addr  (head_addr),
        .head_data  (head_data),
        .not_empty  (not_empty),
        .pending    (pending),
        .pop        (pop),
        .bank_load  (bank_load),
        .bank_row   (bank_row),
        .bank_data  (bank_data),
        .busy       (busy)
    );

    // Reads use the live port address
    bank_array bank_array_i (
        .clk        (clk),
        .reset      (reset),
        .bank_load  (bank_load),
        .bank_row   (bank_row),
        .bank_data  (bank_data),
        .pending    (pending),
        .rd_addr    (addr),
        .rd         (rd)
    );

endmodule

//--- hdl/bank_array.sv
`timescale 1ns/10ps

module bank_array
    import banked_sram_pkg::*;
(
    input  logic                 clk,
    input  logic                 reset,
    input  logic [NUM_BANKS-1:0] bank_load,
    input  logic [ROW_BITS-1:0]  bank_row [NUM_BANKS],
    input  word_t                bank_data [NUM_BANKS],
    output logic [NUM_BANKS-1:0] pending,
    input  mem_addr_u            rd_addr [NUM_PORTS],
    output word_t                rd [NUM_PORTS]
);

    localparam int BANK_WORDS = 1 << ROW_BITS;

    // Bank b holds every word whose address ends in b
    word_t                mem [NUM_BANKS][BANK_WORDS];

    // One staged write per bank
    logic [ROW_BITS-1:0]  wr_row   [NUM_BANKS];
    word_t                wr_data  [NUM_BANKS];
    logic [NUM_BANKS-1:0] wr_valid;

    ////////////////////////////////////////////////////////////
    // Write registers
    ////////////////////////////////////////////////////////////

    always_ff @(posedge clk or posedge reset)
    begin
        if (reset)
            wr_valid <= '0;
        else
            wr_valid <= bank_load;
    end

    always_ff @(posedge clk)
    begin
        for (int b = 0; b < NUM_BANKS; b++)
        begin
            if (bank_load[b])
            begin
                wr_row[b]  <= bank_row[b];
                wr_data[b] <= bank_data[b];
            end
        end
    end

    // Registered write still on its way to the array
    assign pending = wr_valid;

    ////////////////////////////////////////////////////////////
    // Array commit
    ////////////////////////////////////////////////////////////

    // A new write may load while the previous one commits,
    // so each bank takes one write per cycle without stalls
    always_ff @(posedge clk)
    begin
        for (int b = 0; b < NUM_BANKS; b++)
        begin
            if (wr_valid[b])
                mem[b][wr_row[b]] <= wr_data[b];
        end
    end

    ////////////////////////////////////////////////////////////
    // Read ports
    ////////////////////////////////////////////////////////////

    // Array contents only; staged writes are not forwarded
    always_comb
    begin
        for (int p = 0; p < NUM_PORTS; p++)
        begin
            rd[p] = mem[rd_addr[p].split.bank][rd_addr[p].split.row];
        end
    end

endmodule

//--- hdl/bank_arbiter.sv
`timescale 1ns/10ps

module bank_arbiter
    import banked_sram_pkg::*;
(
    input  mem_addr_u            head_addr [NUM_PORTS],
    input  word_t                head_data [NUM_PORTS],
    input  logic [NUM_PORTS-1:0] not_empty,
    input  logic [NUM_BANKS-1:0] pending,
    output logic [NUM_PORTS-1:0] pop,
    output logic [NUM_BANKS-1:0] bank_load,
    output logic [ROW_BITS-1:0]  bank_row [NUM_BANKS],
    output word_t                bank_data [NUM_BANKS],
    output logic                 busy
);

    // req[b][p] is set when port p holds a head aimed at bank b
    logic [NUM_PORTS-1:0] req   [NUM_BANKS];
    logic [NUM_PORTS-1:0] grant [NUM_BANKS];

    ////////////////////////////////////////////////////////////
    // Request matrix
    ////////////////////////////////////////////////////////////

    always_comb
    begin
        for (int b = 0; b < NUM_BANKS; b++)
        begin
            for (int p = 0; p < NUM_PORTS; p++)
            begin
                req[b][p] = not_empty[p]
                    && (head_addr[p].split.bank == BANK_SEL_BITS'(b));
            end
        end
    end

    ////////////////////////////////////////////////////////////
    // Fixed priority with port 0 highest
    ////////////////////////////////////////////////////////////

    // Isolate the lowest set request bit of every bank
    always_comb
    begin
        for (int b = 0; b < NUM_BANKS; b++)
        begin
            grant[b] = req[b] & (~req[b] + NUM_PORTS'(1));
        end
    end

    // Winner's row and data go to the bank write register
    always_comb
    begin
        for (int b = 0; b < NUM_BANKS; b++)
        begin
            bank_load[b] = |req[b];
            bank_row[b]  = '0;
            bank_data[b] = '0;
            for (int p = 0; p < NUM_PORTS; p++)
            begin
                if (grant[b][p])
                begin
                    bank_row[b]  = head_addr[p].split.row;
                    bank_data[b] = head_data[p];
                end
            end
        end
    end

    // A head targets exactly one bank, so a port is granted at most once
    // Losers keep their head and try again next cycle
    always_comb
    begin
        pop = '0;
        for (int b = 0; b < NUM_BANKS; b++)
        begin
            pop = pop | grant[b];
        end
    end

    ////////////////////////////////////////////////////////////
    // Activity
    ////////////////////////////////////////////////////////////

    // Low only once every queued and registered write has landed
    assign busy = (|not_empty) || (|pending);

endmodule

//--- hdl/write_fifo.sv
`timescale 1ns/10ps

module write_fifo
    import banked_sram_pkg::*;
#(
    parameter int FIFO_DEPTH = 4
)
(
    input  logic      clk,
    input  logic      reset,
    input  logic      push,
    input  mem_addr_u push_addr,
    input  word_t     push_data,
    input  logic      pop,
    output mem_addr_u head_addr,
    output word_t     head_data,
    output logic      not_empty,
    output logic      full
);

    localparam int PTR_BITS   = $clog2(FIFO_DEPTH);
    localparam int COUNT_BITS = $clog2(FIFO_DEPTH + 1);

    logic [ADDR_BITS-1:0]  addr_mem [FIFO_DEPTH];
    word_t                 data_mem [FIFO_DEPTH];
    logic [PTR_BITS-1:0]   wr_ptr;
    logic [PTR_BITS-1:0]   rd_ptr;
    logic [COUNT_BITS-1:0] count;
    logic                  do_push;
    logic                  do_pop;

    // Pointers wrap at the depth, which need not be a power of two
    function automatic logic [PTR_BITS-1:0] next_ptr(input logic [PTR_BITS-1:0] ptr);
        if (ptr == PTR_BITS'(FIFO_DEPTH - 1))
            return '0;
        return ptr + PTR_BITS'(1);
    endfunction

    // A push against a full FIFO is dropped
    assign do_push = push && !full;
    assign do_pop  = pop && not_empty;

    assign full      = (count == COUNT_BITS'(FIFO_DEPTH));
    assign not_empty = (count != '0);

    // Entry storage in flat address form
    always_ff @(posedge clk)
    begin
        if (do_push)
        begin
            addr_mem[wr_ptr] <= push_addr.flat;
            data_mem[wr_ptr] <= push_data;
        end
    end

    always_ff @(posedge clk or posedge reset)
    begin
        if (reset)
        begin
            wr_ptr <= '0;
            rd_ptr <= '0;
            count  <= '0;
        end
        else
        begin
            if (do_push)
                wr_ptr <= next_ptr(wr_ptr);
            if (do_pop)
                rd_ptr <= next_ptr(rd_ptr);
            case ({do_push, do_pop})
                2'b10:   count <= count + COUNT_BITS'(1);
                2'b01:   count <= count - COUNT_BITS'(1);
                default: count <= count;
            endcase
        end
    end

    // Head comes straight out of storage
    assign head_addr.flat = addr_mem[rd_ptr];
    assign head_data      = data_mem[rd_ptr];

endmodule

//--- hdl/banked_sram_pkg.sv
package banked_sram_pkg;

    ////////////////////////////////////////////////////////////
    // Memory geometry
    ////////////////////////////////////////////////////////////

    // Access ports with a write FIFO each
    localparam int NUM_PORTS = 4;

    // Interleaved banks of 4K words each
    localparam int NUM_BANKS     = 4;
    localparam int BANK_SEL_BITS = 2;

    // 16K words in total
    localparam int ADDR_BITS = 14;
    localparam int ROW_BITS  = ADDR_BITS - BANK_SEL_BITS;

    ////////////////////////////////////////////////////////////
    // Types
    ////////////////////////////////////////////////////////////

    typedef logic [31:0] word_t;

    // Word address seen either as one flat index or as row and bank
    // Bank sits in the low bits so that consecutive words interleave
    typedef union packed
    {
        logic [ADDR_BITS-1:0] flat;
        struct packed
        {
            logic [ROW_BITS-1:0]      row;
            logic [BANK_SEL_BITS-1:0] bank;
        } split;
    } mem_addr_u;

endpackage
